// File: src/isaPkg.sv
package isaPkg;

    typedef enum logic [3:0] {
        ADD    = 4'h0,
        SUB    = 4'h1,
        XOR    = 4'h2,
        RED    = 4'h3,
        SLL    = 4'h4,
        SRA    = 4'h5,
        ROR    = 4'h6,
        PADDSB = 4'h7,
        LW     = 4'h8,
        SW     = 4'h9,
        LLB    = 4'ha,
        LHB    = 4'hb,
        B      = 4'hc,
        BR     = 4'hd,
        PCS    = 4'he,
        HLT    = 4'hf
    } opcodeT;

    typedef enum logic [2:0] {
        NE     = 3'd0,
        EQ     = 3'd1,
        GT     = 3'd2,
        LT     = 3'd3,
        GE     = 3'd4,
        LE     = 3'd5,
        OVF    = 3'd6,
        ALWAYS = 3'd7
    } condT;

    localparam int OpMsb   = 15;
    localparam int RdMsb   = 11;
    localparam int CondMsb = 11; // B and BR only
    localparam int RsMsb   = 7;
    localparam int RtMsb   = 3;  // Also imm4 for shifts and memory
    localparam int Imm8Msb = 7;
    localparam int Imm9Msb = 8;

endpackage

// File: src/coreCfgPkg.sv
package coreCfgPkg;

    localparam int DataWidth = 16;

    localparam int RegCount     = 16;
    localparam int RegAddrWidth = 4;

    // Instruction index, the byte address is one bit wider
    localparam int ProgDepth     = 256;
    localparam int ProgAddrWidth = 8;

    localparam int DataDepth     = 256; // 16-bit words
    localparam int DataAddrWidth = 8;

endpackage

// File: src/control.sv
`timescale 1ns/1ps

module control (
    input  isaPkg::opcodeT opcode,
    output logic           RegDst,
    output logic           Branch,
    output logic           BranchReg,
    output logic           MemtoReg,
    output logic           MemRead,
    output logic           AluSrc,
    output logic           MemWrite,
    output logic           MemHalf,
    output logic           RegWrite,
    output logic           PC,
    output logic           Halt
);

    always_comb begin
        RegDst    = 1'b0;
        Branch    = 1'b0;
        BranchReg = 1'b0;
        MemtoReg  = 1'b0;
        MemRead   = 1'b0;
        AluSrc    = 1'b0;
        MemWrite  = 1'b0;
        MemHalf   = 1'b0;
        RegWrite  = 1'b0;
        PC        = 1'b0;
        Halt      = 1'b0;
        case (opcode)
            isaPkg::ADD, isaPkg::SUB, isaPkg::XOR, isaPkg::RED, isaPkg::PADDSB: begin
                RegDst   = 1'b1; // Second operand from rt
                AluSrc   = 1'b1;
                RegWrite = 1'b1;
            end
            isaPkg::SLL, isaPkg::SRA, isaPkg::ROR: begin
                RegDst   = 1'b1;
                RegWrite = 1'b1; // Immediate shift amount
            end
            isaPkg::LW: begin
                MemRead  = 1'b1;
                MemtoReg = 1'b1;
                RegWrite = 1'b1;
            end
            isaPkg::SW: begin
                MemRead  = 1'b1;
                MemWrite = 1'b1;
            end
            isaPkg::LLB, isaPkg::LHB: begin
                MemHalf  = 1'b1;
                RegWrite = 1'b1;
            end
            isaPkg::B: begin
                Branch = 1'b1;
            end
            isaPkg::BR: begin
                Branch    = 1'b1;
                BranchReg = 1'b1;
            end
            isaPkg::PCS: begin
                PC = 1'b1;
            end
            isaPkg::HLT: begin
                Halt = 1'b1;
            end
            default: begin
                Halt = 1'b0; // Everything stays low
            end
        endcase
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [coreCfgPkg::RegAddrWidth-1:0] rdAddrA,
    input  logic [coreCfgPkg::RegAddrWidth-1:0] rdAddrB,
    input  logic                                wrEn,
    input  logic [coreCfgPkg::RegAddrWidth-1:0] wrAddr,
    input  logic [coreCfgPkg::DataWidth-1:0]    wrData,
    output logic [coreCfgPkg::DataWidth-1:0]    rdDataA,
    output logic [coreCfgPkg::DataWidth-1:0]    rdDataB
);

    logic [coreCfgPkg::DataWidth-1:0] regs [coreCfgPkg::RegCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < coreCfgPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // No bypass, a write shows up the cycle after
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    input  isaPkg::opcodeT                   opcode,
    input  logic [coreCfgPkg::DataWidth-1:0] opA,
    input  logic [coreCfgPkg::DataWidth-1:0] opB,
    input  logic [3:0]                       shamt,
    output logic [coreCfgPkg::DataWidth-1:0] result,
    output logic                             zero,
    output logic                             overflow,
    output logic                             negative,
    output logic                             setZ,
    output logic                             setVN
);

    logic [coreCfgPkg::DataWidth:0]     sum;  // One guard bit
    logic [coreCfgPkg::DataWidth:0]     diff;
    logic                               addOvf;
    logic                               subOvf;
    logic [9:0]                         redSum;
    logic [2*coreCfgPkg::DataWidth-1:0] rotWide;
    logic [coreCfgPkg::DataWidth-1:0]   nibbleSum;

    function automatic logic [3:0] satNibble(input logic [3:0] a, input logic [3:0] b);
        logic [4:0] s;
        s = {a[3], a} + {b[3], b};
        if (s[4] != s[3]) begin
            return s[4] ? 4'h8 : 4'h7;
        end
        return s[3:0];
    endfunction

    assign sum    = {opA[15], opA} + {opB[15], opB};
    assign diff   = {opA[15], opA} - {opB[15], opB};
    assign addOvf = sum[16] ^ sum[15];
    assign subOvf = diff[16] ^ diff[15];

    // Signed bytes of both operands
    assign redSum = {{2{opA[15]}}, opA[15:8]} + {{2{opA[7]}}, opA[7:0]}
                  + {{2{opB[15]}}, opB[15:8]} + {{2{opB[7]}}, opB[7:0]};

    assign rotWide = {opA, opA} >> shamt;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            nibbleSum[4*i +: 4] = satNibble(opA[4*i +: 4], opB[4*i +: 4]);
        end
    end

    always_comb begin
        overflow = 1'b0;
        case (opcode)
            isaPkg::ADD: begin
                result   = addOvf ? {sum[16], {15{~sum[16]}}} : sum[15:0]; // Saturate
                overflow = addOvf;
            end
            isaPkg::SUB: begin
                result   = subOvf ? {diff[16], {15{~diff[16]}}} : diff[15:0];
                overflow = subOvf;
            end
            isaPkg::XOR:    result = opA ^ opB;
            isaPkg::RED:    result = {{6{redSum[9]}}, redSum};
            isaPkg::SLL:    result = opA << shamt;
            isaPkg::SRA:    result = $signed(opA) >>> shamt;
            isaPkg::ROR:    result = rotWide[15:0];
            isaPkg::PADDSB: result = nibbleSum;
            default:        result = opA + opB; // Address sum
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[15];

    always_comb begin
        setZ  = 1'b0;
        setVN = 1'b0;
        case (opcode)
            isaPkg::ADD, isaPkg::SUB: begin
                setZ  = 1'b1;
                setVN = 1'b1;
            end
            isaPkg::XOR, isaPkg::SLL, isaPkg::SRA, isaPkg::ROR: setZ = 1'b1;
            default: setZ = 1'b0;
        endcase
    end

endmodule

// File: src/branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [coreCfgPkg::DataWidth-1:0] pc,
    input  isaPkg::condT                     cond,
    input  logic [8:0]                       imm9,
    input  logic [coreCfgPkg::DataWidth-1:0] target,
    input  logic                             Branch,
    input  logic                             BranchReg,
    input  logic                             zero,
    input  logic                             overflow,
    input  logic                             negative,
    input  logic                             setZ,
    input  logic                             setVN,
    input  logic                             stall,
    output logic [coreCfgPkg::DataWidth-1:0] nextPc
);

    logic                             zFlag;
    logic                             vFlag;
    logic                             nFlag;
    logic                             taken;
    logic [coreCfgPkg::DataWidth-1:0] pcPlus2;
    logic [coreCfgPkg::DataWidth-1:0] relTarget;

    always_ff @(posedge clk) begin
        if (rst) begin
            zFlag <= 1'b0;
            vFlag <= 1'b0;
            nFlag <= 1'b0;
        end else if (!stall) begin
            if (setZ) zFlag <= zero;
            if (setVN) begin
                vFlag <= overflow;
                nFlag <= negative;
            end
        end
    end

    always_comb begin
        case (cond)
            isaPkg::NE:  taken = !zFlag;
            isaPkg::EQ:  taken = zFlag;
            isaPkg::GT:  taken = !zFlag && !nFlag;
            isaPkg::LT:  taken = nFlag;
            isaPkg::GE:  taken = zFlag || !nFlag;
            isaPkg::LE:  taken = nFlag || zFlag;
            isaPkg::OVF: taken = vFlag;
            default:     taken = 1'b1;
        endcase
    end

    assign pcPlus2   = pc + 16'd2;
    assign relTarget = pcPlus2 + {{6{imm9[8]}}, imm9, 1'b0}; // Halfword offset

    always_comb begin
        if (Branch && taken) begin
            nextPc = BranchReg ? target : relTarget;
        end else begin
            nextPc = pcPlus2;
        end
    end

endmodule

// File: src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 progWrEn,
    input  logic [coreCfgPkg::ProgAddrWidth-1:0] progAddr,
    input  logic [coreCfgPkg::DataWidth-1:0]     progData,
    input  logic [coreCfgPkg::DataWidth-1:0]     nextPc,
    input  logic                                 Halt,
    output logic [coreCfgPkg::DataWidth-1:0]     pc,
    output logic [coreCfgPkg::DataWidth-1:0]     instr,
    output logic                                 halted
);

    logic [coreCfgPkg::DataWidth-1:0] progMem [coreCfgPkg::ProgDepth];

    // Loader port only works during reset
    always_ff @(posedge clk) begin
        if (rst && progWrEn) begin
            progMem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (Halt) begin
                halted <= 1'b1; // PC stays on the HLT
            end else begin
                pc <= nextPc;
            end
        end
    end

    // Byte address to instruction index
    assign instr = progMem[pc[coreCfgPkg::ProgAddrWidth:1]];

endmodule

// File: src/dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic                                 clk,
    input  logic                                 wrEn,
    input  logic [coreCfgPkg::DataAddrWidth-1:0] addr,
    input  logic [coreCfgPkg::DataWidth-1:0]     wrData,
    output logic [coreCfgPkg::DataWidth-1:0]     rdData
);

    logic [coreCfgPkg::DataWidth-1:0] mem [coreCfgPkg::DataDepth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

    assign rdData = mem[addr]; // Async read

endmodule

// File: src/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 progWrEn,
    input  logic [coreCfgPkg::ProgAddrWidth-1:0] progAddr,
    input  logic [coreCfgPkg::DataWidth-1:0]     progData,
    output logic [coreCfgPkg::DataWidth-1:0]     pc,
    output logic                                 halted,
    output logic                                 regWrEn,
    output logic [coreCfgPkg::RegAddrWidth-1:0]  regWrAddr,
    output logic [coreCfgPkg::DataWidth-1:0]     regWrData,
    output logic                                 memWrEn,
    output logic [coreCfgPkg::DataWidth-1:0]     memAddr,
    output logic [coreCfgPkg::DataWidth-1:0]     memWrData
);

    logic [coreCfgPkg::DataWidth-1:0]    instr;
    logic [coreCfgPkg::DataWidth-1:0]    nextPc;
    logic [coreCfgPkg::DataWidth-1:0]    pcPlus2;
    isaPkg::opcodeT                      opcode;
    isaPkg::condT                        cond;
    logic [coreCfgPkg::RegAddrWidth-1:0] rd;
    logic [coreCfgPkg::RegAddrWidth-1:0] rs;
    logic [coreCfgPkg::RegAddrWidth-1:0] rt;
    logic [7:0]                          imm8;
    logic [8:0]                          imm9;
    logic                                RegDst;
    logic                                Branch;
    logic                                BranchReg;
    logic                                MemtoReg;
    logic                                MemRead;
    logic                                AluSrc;
    logic                                MemWrite;
    logic                                MemHalf;
    logic                                RegWrite;
    logic                                PC;
    logic                                Halt;
    logic                                idle;
    logic [coreCfgPkg::RegAddrWidth-1:0] rdAddrB;
    logic [coreCfgPkg::DataWidth-1:0]    rdDataA;
    logic [coreCfgPkg::DataWidth-1:0]    rdDataB;
    logic [coreCfgPkg::DataWidth-1:0]    opB;
    logic [coreCfgPkg::DataWidth-1:0]    aluResult;
    logic                                zero;
    logic                                overflow;
    logic                                negative;
    logic                                setZ;
    logic                                setVN;
    logic [coreCfgPkg::DataWidth-1:0]    memRdData;
    logic [coreCfgPkg::DataWidth-1:0]    byteMerge;

    assign opcode = isaPkg::opcodeT'(instr[isaPkg::OpMsb -: 4]);
    assign cond   = isaPkg::condT'(instr[isaPkg::CondMsb -: 3]);
    assign rd     = instr[isaPkg::RdMsb -: 4];
    assign rs     = instr[isaPkg::RsMsb -: 4];
    assign rt     = instr[isaPkg::RtMsb -: 4];
    assign imm8   = instr[isaPkg::Imm8Msb -: 8];
    assign imm9   = instr[isaPkg::Imm9Msb -: 9];

    assign idle    = rst | halted; // Nothing retires
    assign pcPlus2 = pc + 16'd2;
    assign rdAddrB = RegDst ? rt : rd; // rd gives store data and the old byte
    assign opB     = AluSrc ? rdDataB : {11'd0, rt, 1'b0}; // imm4 as halfword offset

    fetchUnit u_fetch (
        .clk     (clk),
        .rst     (rst),
        .progWrEn(progWrEn),
        .progAddr(progAddr),
        .progData(progData),
        .nextPc  (nextPc),
        .Halt    (Halt),
        .pc      (pc),
        .instr   (instr),
        .halted  (halted)
    );

    control u_control (
        .opcode   (opcode),
        .RegDst   (RegDst),
        .Branch   (Branch),
        .BranchReg(BranchReg),
        .MemtoReg (MemtoReg),
        .MemRead  (MemRead),
        .AluSrc   (AluSrc),
        .MemWrite (MemWrite),
        .MemHalf  (MemHalf),
        .RegWrite (RegWrite),
        .PC       (PC),
        .Halt     (Halt)
    );

    regFile u_regFile (
        .clk    (clk),
        .rst    (rst),
        .rdAddrA(rs),
        .rdAddrB(rdAddrB),
        .wrEn   (regWrEn),
        .wrAddr (regWrAddr),
        .wrData (regWrData),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB)
    );

    alu u_alu (
        .opcode  (opcode),
        .opA     (rdDataA),
        .opB     (opB),
        .shamt   (rt),
        .result  (aluResult),
        .zero    (zero),
        .overflow(overflow),
        .negative(negative),
        .setZ    (setZ),
        .setVN   (setVN)
    );

    branchUnit u_branch (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .cond     (cond),
        .imm9     (imm9),
        .target   (rdDataA),
        .Branch   (Branch),
        .BranchReg(BranchReg),
        .zero     (zero),
        .overflow (overflow),
        .negative (negative),
        .setZ     (setZ),
        .setVN    (setVN),
        .stall    (halted),
        .nextPc   (nextPc)
    );

    dataMem u_dataMem (
        .clk   (clk),
        .wrEn  (memWrEn),
        .addr  (aluResult[coreCfgPkg::DataAddrWidth:1]),
        .wrData(rdDataB),
        .rdData(memRdData)
    );

    // LHB keeps the low byte, LLB the high byte
    assign byteMerge = (opcode == isaPkg::LHB) ? {imm8, rdDataB[7:0]} : {rdDataB[15:8], imm8};

    always_comb begin
        if (PC) begin
            regWrData = pcPlus2;
        end else if (MemHalf) begin
            regWrData = byteMerge;
        end else if (MemtoReg && MemRead) begin
            regWrData = memRdData;
        end else begin
            regWrData = aluResult;
        end
    end

    // PCS writes back even though the decoder leaves RegWrite low
    assign regWrEn   = (RegWrite | PC) & ~idle & (rd != '0);
    assign regWrAddr = rd;

    assign memWrEn   = MemWrite & ~idle;
    assign memAddr   = aluResult;
    assign memWrData = rdDataB;

endmodule

// File: dv/cpuModel.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [15:0] mReg [16];
logic [15:0] mData [256]; // Survives reset like the DUT memory
logic [15:0] mPc;
logic        mZ;
logic        mV;
logic        mN;
logic        mHalted;

function automatic void modelReset();
    for (int i = 0; i < 16; i++) begin
        mReg[i] = 16'h0;
    end
    mPc     = 16'h0;
    mZ      = 1'b0;
    mV      = 1'b0;
    mN      = 1'b0;
    mHalted = 1'b0;
endfunction

function automatic logic condHolds(logic [2:0] c);
    case (isaPkg::condT'(c))
        isaPkg::NE:  return !mZ;
        isaPkg::EQ:  return mZ;
        isaPkg::GT:  return !mZ && !mN;
        isaPkg::LT:  return mN;
        isaPkg::GE:  return mZ || !mN;
        isaPkg::LE:  return mN || mZ;
        isaPkg::OVF: return mV;
        default:     return 1'b1;
    endcase
endfunction

// One instruction on the model state, returns the writes it should make
function automatic void cpuStep(
    input  logic [15:0] instr,
    output logic        expRegWe,
    output logic [3:0]  expRegAddr,
    output logic [15:0] expRegData,
    output logic        expMemWe,
    output logic [15:0] expMemAddr,
    output logic [15:0] expMemData
);
    isaPkg::opcodeT op;
    logic [3:0]     rd;
    logic [3:0]     rt;
    logic [15:0]    a;
    logic [15:0]    b;
    logic [15:0]    res;
    logic [15:0]    nextPc;
    logic           ovf;
    int             acc;
    op         = isaPkg::opcodeT'(instr[15:12]);
    rd         = instr[11:8];
    rt         = instr[3:0];
    a          = mReg[instr[7:4]];
    b          = mReg[rt];
    res        = 16'h0;
    ovf        = 1'b0;
    nextPc     = mPc + 16'd2;
    expMemWe   = 1'b0;
    expMemAddr = a + {11'd0, rt, 1'b0};
    expMemData = mReg[rd];
    case (op)
        isaPkg::ADD, isaPkg::SUB: begin
            acc = int'($signed(a));
            acc = (op == isaPkg::ADD) ? acc + int'($signed(b)) : acc - int'($signed(b));
            if (acc > 32767) begin
                res = 16'h7fff;
                ovf = 1'b1;
            end else if (acc < -32768) begin
                res = 16'h8000;
                ovf = 1'b1;
            end else begin
                res = acc[15:0];
            end
            mV = ovf;
            mN = res[15];
        end
        isaPkg::XOR: res = a ^ b;
        isaPkg::RED: begin
            acc = int'($signed(a[15:8])) + int'($signed(a[7:0]))
                + int'($signed(b[15:8])) + int'($signed(b[7:0]));
            res = acc[15:0];
        end
        isaPkg::SLL: res = a << rt;
        isaPkg::SRA: res = $signed(a) >>> rt;
        isaPkg::ROR: res = (a >> rt) | (a << (5'd16 - {1'b0, rt}));
        isaPkg::PADDSB: begin
            for (int i = 0; i < 4; i++) begin
                acc = int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4]));
                if (acc > 7) acc = 7;
                if (acc < -8) acc = -8;
                res[4*i +: 4] = acc[3:0];
            end
        end
        isaPkg::LW:  res = mData[expMemAddr[8:1]];
        isaPkg::SW: begin
            expMemWe = 1'b1;
            mData[expMemAddr[8:1]] = mReg[rd];
        end
        isaPkg::LLB: res = {mReg[rd][15:8], instr[7:0]};
        isaPkg::LHB: res = {instr[7:0], mReg[rd][7:0]};
        isaPkg::B: begin
            if (condHolds(instr[11:9])) nextPc = nextPc + {{6{instr[8]}}, instr[8:0], 1'b0};
        end
        isaPkg::BR: begin
            if (condHolds(instr[11:9])) nextPc = a;
        end
        isaPkg::PCS: res = mPc + 16'd2;
        default: begin
            nextPc  = mPc; // HLT
            mHalted = 1'b1;
        end
    endcase
    if (op inside {isaPkg::ADD, isaPkg::SUB, isaPkg::XOR, isaPkg::SLL, isaPkg::SRA, isaPkg::ROR})
        mZ = (res == 16'h0);
    expRegWe   = !(op inside {isaPkg::SW, isaPkg::B, isaPkg::BR, isaPkg::HLT}) && (rd != 4'h0);
    expRegAddr = rd;
    expRegData = res;
    if (expRegWe) mReg[rd] = res;
    mPc = nextPc;
endfunction

`endif

// File: dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    localparam int NumRandom      = 4;
    localparam int NumPrograms    = 4 + NumRandom;
    localparam int MaxProgLen     = 128;
    localparam int WatchdogCycles = NumPrograms * (2 * MaxProgLen + 10); // Load plus run

    logic                                 clk;
    logic                                 rst;
    logic                                 progWrEn;
    logic [coreCfgPkg::ProgAddrWidth-1:0] progAddr;
    logic [coreCfgPkg::DataWidth-1:0]     progData;
    logic [coreCfgPkg::DataWidth-1:0]     pc;
    logic                                 halted;
    logic                                 regWrEn;
    logic [coreCfgPkg::RegAddrWidth-1:0]  regWrAddr;
    logic [coreCfgPkg::DataWidth-1:0]     regWrData;
    logic                                 memWrEn;
    logic [coreCfgPkg::DataWidth-1:0]     memAddr;
    logic [coreCfgPkg::DataWidth-1:0]     memWrData;

    logic [15:0] prog [$];
    logic [15:0] progImg [256];
    logic        running;
    integer      seed;

    `include "cpuModel.svh"

    cpu i_cpu (
        .clk      (clk),
        .rst      (rst),
        .progWrEn (progWrEn),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .halted   (halted),
        .regWrEn  (regWrEn),
        .regWrAddr(regWrAddr),
        .regWrData(regWrData),
        .memWrEn  (memWrEn),
        .memAddr  (memAddr),
        .memWrData(memWrData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic reportMismatch(string sig, logic [15:0] expVal, logic [15:0] actVal);
        $display("ERROR at %0t: %s expected %h, got %h", $time, sig, expVal, actVal);
        $display("Test failed");
        $fatal(1, "Stopped on first mismatch");
    endtask

    function automatic void addInstr(isaPkg::opcodeT op, int rd, int rs, int rt);
        prog.push_back({op, rd[3:0], rs[3:0], rt[3:0]});
    endfunction

    function automatic void constPair(int rd, logic [15:0] value);
        prog.push_back({isaPkg::LLB, rd[3:0], value[7:0]});
        prog.push_back({isaPkg::LHB, rd[3:0], value[15:8]});
    endfunction

    function automatic void arithProgram();
        constPair(1, 16'h7fff);
        constPair(2, 16'h0001);
        constPair(4, 16'h8000);
        addInstr(isaPkg::ADD, 3, 1, 2); // Saturates high
        addInstr(isaPkg::SUB, 5, 4, 2); // Saturates low
        addInstr(isaPkg::ADD, 6, 4, 4);
        addInstr(isaPkg::SUB, 7, 1, 4);
        addInstr(isaPkg::ADD, 8, 2, 2);
        addInstr(isaPkg::SUB, 8, 2, 2);
        constPair(9, 16'h7a37);
        constPair(10, 16'h18c5);
        addInstr(isaPkg::PADDSB, 11, 9, 10); // Mixed nibble saturation
        addInstr(isaPkg::PADDSB, 12, 10, 10);
        addInstr(isaPkg::ADD, 0, 1, 2);
        addInstr(isaPkg::ADD, 13, 0, 2); // r0 must still read zero
        addInstr(isaPkg::PCS, 0, 0, 0);
        addInstr(isaPkg::XOR, 14, 0, 2);
        addInstr(isaPkg::HLT, 0, 0, 0);
    endfunction

    function automatic void logicProgram();
        logic [31:0] r;
        int          sh;
        r = $random(seed);
        constPair(1, r[15:0] | 16'h8000); // Negative so SRA fills with ones
        constPair(2, r[31:16]);
        addInstr(isaPkg::XOR, 3, 1, 2);
        addInstr(isaPkg::RED, 4, 1, 2);
        addInstr(isaPkg::RED, 5, 2, 2);
        for (int i = 0; i < 4; i++) begin
            r  = $random(seed);
            sh = (i == 0) ? 0 : (i == 1) ? 15 : int'(r[3:0]);
            addInstr(isaPkg::SLL, 6, 1, sh);
            addInstr(isaPkg::SRA, 7, 1, sh);
            addInstr(isaPkg::SRA, 8, 2, sh);
            addInstr(isaPkg::ROR, 9, 1, sh);
        end
        addInstr(isaPkg::HLT, 0, 0, 0);
    endfunction

    function automatic void memoryProgram();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            constPair(2, r[15:0]);
            addInstr(isaPkg::SW, 2, 0, i); // Word i
        end
        for (int i = 0; i < 16; i++) begin
            addInstr(isaPkg::LW, 3 + i % 12, 0, i);
        end
        constPair(5, 16'h0040);
        addInstr(isaPkg::SW, 3, 5, 7);
        addInstr(isaPkg::LW, 6, 5, 7);
        addInstr(isaPkg::HLT, 0, 0, 0);
    endfunction

    function automatic void branchProgram();
        int          n;
        logic [15:0] target;
        constPair(1, 16'h7fff);
        constPair(2, 16'h0001);
        constPair(7, 16'h8000);
        for (int s = 0; s < 5; s++) begin
            case (s)
                0: addInstr(isaPkg::SUB, 3, 1, 1); // Z only
                1: addInstr(isaPkg::SUB, 3, 0, 2); // N only
                2: addInstr(isaPkg::ADD, 3, 2, 2);
                3: addInstr(isaPkg::ADD, 3, 7, 7); // V and N
                default: addInstr(isaPkg::XOR, 3, 1, 1); // Sets Z and keeps V and N
            endcase
            for (int c = 0; c < 8; c++) begin
                prog.push_back({isaPkg::B, 3'(c), 9'd1});
                prog.push_back({isaPkg::LLB, 4'd4, 8'(s * 8 + c)}); // Skipped when taken
            end
        end
        n      = prog.size();
        target = 16'((n + 5) * 2);
        constPair(5, target);
        prog.push_back({isaPkg::BR, isaPkg::NE, 1'b0, 4'd5, 4'd0});
        prog.push_back({isaPkg::BR, isaPkg::ALWAYS, 1'b0, 4'd5, 4'd0});
        prog.push_back({isaPkg::LLB, 4'd4, 8'hee});
        addInstr(isaPkg::PCS, 6, 0, 0);
        addInstr(isaPkg::PCS, 0, 0, 0);
        addInstr(isaPkg::HLT, 0, 0, 0);
    endfunction

    function automatic void randomProgram();
        logic [31:0] r;
        logic [3:0]  op;
        for (int i = 0; i < 39; i++) begin
            r  = $random(seed);
            op = r[15:12];
            if (op == isaPkg::B || op == isaPkg::BR || op == isaPkg::HLT) op = isaPkg::LLB;
            if (op == isaPkg::LW) r[7:4] = 4'h0; // Words 0 to 15 are known
            prog.push_back({op, r[11:0]});
        end
        addInstr(isaPkg::HLT, 0, 0, 0);
    endfunction

    // Load under reset, then run until the core halts
    task automatic runProgram();
        int len;
        int cycles;
        len    = prog.size();
        cycles = (len > 5) ? len : 5;
        rst <= 1'b1;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (i < len) begin
                progWrEn   <= 1'b1;
                progAddr   <= i[7:0];
                progData   <= prog[i];
                progImg[i] = prog[i];
            end else begin
                progWrEn <= 1'b0;
            end
        end
        @(posedge clk);
        progWrEn <= 1'b0;
        rst      <= 1'b0;
        modelReset();
        running = 1'b1;
        wait (halted === 1'b1);
        repeat (4) @(posedge clk); // Watch the frozen state
        running = 1'b0;
        prog.delete();
    endtask

    always @(negedge clk) begin
        logic        eRegWe;
        logic [3:0]  eRegAddr;
        logic [15:0] eRegData;
        logic        eMemWe;
        logic [15:0] eMemAddr;
        logic [15:0] eMemData;
        if (running && !mHalted) begin
            assert (halted === 1'b0) else reportMismatch("halted", 16'h0, {15'd0, halted});
            assert (pc === mPc) else reportMismatch("pc", mPc, pc);
            cpuStep(progImg[mPc[8:1]], eRegWe, eRegAddr, eRegData, eMemWe, eMemAddr, eMemData);
            assert (regWrEn === eRegWe)
                else reportMismatch("regWrEn", {15'd0, eRegWe}, {15'd0, regWrEn});
            if (eRegWe) begin
                assert (regWrAddr === eRegAddr)
                    else reportMismatch("regWrAddr", {12'd0, eRegAddr}, {12'd0, regWrAddr});
                assert (regWrData === eRegData)
                    else reportMismatch("regWrData", eRegData, regWrData);
            end
            assert (memWrEn === eMemWe)
                else reportMismatch("memWrEn", {15'd0, eMemWe}, {15'd0, memWrEn});
            if (eMemWe) begin
                assert (memAddr === eMemAddr) else reportMismatch("memAddr", eMemAddr, memAddr);
                assert (memWrData === eMemData)
                    else reportMismatch("memWrData", eMemData, memWrData);
            end
        end else if (running) begin
            assert (halted === 1'b1) else reportMismatch("halted", 16'h1, {15'd0, halted});
            assert (pc === mPc) else reportMismatch("pc", mPc, pc);
            assert (regWrEn === 1'b0) else reportMismatch("regWrEn", 16'h0, {15'd0, regWrEn});
            assert (memWrEn === 1'b0) else reportMismatch("memWrEn", 16'h0, {15'd0, memWrEn});
        end else if (rst) begin
            assert (regWrEn === 1'b0) else reportMismatch("regWrEn", 16'h0, {15'd0, regWrEn});
            assert (memWrEn === 1'b0) else reportMismatch("memWrEn", 16'h0, {15'd0, memWrEn});
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired: the processor never halted");
        $display("Test failed");
        $fatal(1, "Timeout");
    end

    initial begin
        seed     = 88;
        rst      = 1'b1;
        progWrEn = 1'b0;
        progAddr = '0;
        progData = '0;
        running  = 1'b0;
        arithProgram();
        runProgram();
        logicProgram();
        runProgram();
        memoryProgram(); // Must run before the random programs load words 0 to 15
        runProgram();
        branchProgram();
        runProgram();
        for (int p = 0; p < NumRandom; p++) begin
            randomProgram();
            runProgram();
        end
        $display("Test passed");
        $finish;
    end

endmodule

// File: cpu.f
+incdir+dv
src/isaPkg.sv
src/coreCfgPkg.sv
src/control.sv
src/regFile.sv
src/alu.sv
src/branchUnit.sv
src/fetchUnit.sv
src/dataMem.sv
src/cpu.sv
dv/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator
set -u

cd "$(dirname "$0")"

verilator --binary --assert --top-module cpuTb -f cpu.f -o cpuSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/cpuSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
